//--- src/conv_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the 3x3 convolution datapath
// Widths, beat opcodes and the records passed from stage to stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package conv_pkg;

    // Pixel and weight width
    localparam int PIX_W = 16;

    // Adder tree width, nine full-scale products plus bias fit easily
    localparam int ACC_W = 40;

    // Width of a result on the master port
    localparam int OUT_W = 32;

    // Opcode carried in s_axis_tuser
    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,
        OP_PIXEL  = 2'd1,
        OP_KERNEL = 2'd2,
        OP_BIAS   = 2'd3
    } conv_op_e;

    typedef logic signed [PIX_W-1:0] pix_t;

    // Weight k at position k, k = row * 3 + column
    typedef pix_t [8:0] kernel_t;

    // Decode to execute
    typedef struct packed {
        logic valid;
        pix_t data;
    } pix_beat_t;

    // One 3x3 window, same order as kernel_t
    typedef struct packed {
        logic       valid;
        logic       last;
        pix_t [8:0] px;
    } window_t;

    // Adder tree result
    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic signed [ACC_W-1:0] acc;
    } sum_t;

endpackage

//--- src/conv_stream_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input beat decoder, holds kernel and bias, forwards pixels
// Pixel beats are accepted only against free output FIFO credit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module conv_stream_decoder
    import conv_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                               clk,
    input  logic                               rst_reg_last_chan,
    input  logic [9*PIX_W-1:0]                 s_axis_tdata,
    input  conv_op_e                           s_axis_tuser,
    input  logic                               s_axis_tvalid,
    output logic                               s_axis_tready,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]    free_slots,
    input  logic                               retire_lb,
    input  logic                               retire_out,
    output pix_beat_t                          pix,
    output kernel_t                            kernel,
    output pix_t                               bias
);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic             ready_en;
    logic [CNT_W-1:0] in_flight;
    logic             credit_ok;
    logic             pix_acc;
    logic             ker_acc;
    logic             bias_acc;

    // One more pixel fits only if every pixel in flight already has a slot
    assign credit_ok     = free_slots > in_flight;
    assign s_axis_tready = ready_en && ((s_axis_tuser != OP_PIXEL) || credit_ok);

    always_comb begin
        pix_acc  = 1'b0;
        ker_acc  = 1'b0;
        bias_acc = 1'b0;
        if (s_axis_tvalid && s_axis_tready) begin
            case (s_axis_tuser)
                OP_PIXEL:  pix_acc  = 1'b1;
                OP_KERNEL: ker_acc  = 1'b1;
                OP_BIAS:   bias_acc = 1'b1;
                // OP_NOP is taken and dropped
                default:   ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_reg_last_chan) begin
            ready_en  <= 1'b0;
            in_flight <= '0;
            pix.valid <= 1'b0;
            kernel    <= '0;
            bias      <= '0;
        end else begin
            ready_en  <= 1'b1;
            // Both retire sources may fire in the same cycle
            in_flight <= in_flight + CNT_W'(pix_acc) - CNT_W'(retire_lb) - CNT_W'(retire_out);
            pix.valid <= pix_acc;
            if (ker_acc) begin
                kernel <= kernel_t'(s_axis_tdata);
            end
            if (bias_acc) begin
                bias <= pix_t'(s_axis_tdata[PIX_W-1:0]);
            end
        end
        if (pix_acc) begin
            pix.data <= pix_t'(s_axis_tdata[PIX_W-1:0]);
        end
    end

endmodule

//--- src/conv_line_buffer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line buffer that turns a row-major pixel stream into 3x3 windows
// Two row memories feed a shifting window register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module conv_line_buffer
    import conv_pkg::*;
#(
    parameter int IMG_W = 8
) (
    input  logic      clk,
    input  logic      rst_reg_last_chan,
    input  pix_beat_t pix,
    output window_t   window,
    output logic      retire
);
    localparam int CW = (IMG_W > 1) ? $clog2(IMG_W) : 1;

    // row1 holds the previous row, row2 the one before it
    pix_t row1_mem [IMG_W];
    pix_t row2_mem [IMG_W];

    pix_t [8:0]    win_px;
    logic          win_vld;
    logic          win_last;
    logic [CW-1:0] col;
    logic [CW-1:0] row;
    logic          col_end;
    logic          row_end;
    logic          win_ok;
    pix_t          top_px;
    pix_t          mid_px;

    assign col_end = (col == CW'(IMG_W - 1));
    assign row_end = (row == CW'(IMG_W - 1));
    assign win_ok  = (row >= CW'(2)) && (col >= CW'(2));

    // Column entering the window, oldest row first
    assign top_px = row2_mem[col];
    assign mid_px = row1_mem[col];

    // Pixels on the first two rows or columns never reach the FIFO
    assign retire = pix.valid && !win_ok;

    assign window = {win_vld, win_last, win_px};

    // Row and column position of the incoming pixel
    always_ff @(posedge clk) begin
        if (!rst_reg_last_chan) begin
            col <= '0;
            row <= '0;
        end else if (pix.valid) begin
            if (col_end) begin
                col <= '0;
                row <= row_end ? '0 : row + CW'(1);
            end else begin
                col <= col + CW'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_reg_last_chan) begin
            win_vld  <= 1'b0;
            win_last <= 1'b0;
        end else begin
            win_vld  <= pix.valid && win_ok;
            win_last <= pix.valid && win_ok && row_end && col_end;
        end
    end

    // Row memories and window shift
    always_ff @(posedge clk) begin
        if (pix.valid) begin
            row2_mem[col] <= mid_px;
            row1_mem[col] <= pix.data;
            for (int r = 0; r < 3; r++) begin
                win_px[r*3]   <= win_px[r*3+1];
                win_px[r*3+1] <= win_px[r*3+2];
            end
            win_px[2] <= top_px;
            win_px[5] <= mid_px;
            win_px[8] <= pix.data;
        end
    end

endmodule

//--- src/conv_mac_array.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Nine-way multiply and adder tree, two register stages
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module conv_mac_array
    import conv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_reg_last_chan,
    input  window_t window,
    input  kernel_t kernel,
    output sum_t    sum
);
    localparam int PROD_W = 2 * PIX_W;

    logic signed [PROD_W-1:0] prod [9];
    logic                     prod_vld;
    logic                     prod_last;
    logic signed [ACC_W-1:0]  tree_sum;

    // Stage 1 flags
    always_ff @(posedge clk) begin
        if (!rst_reg_last_chan) begin
            prod_vld  <= 1'b0;
            prod_last <= 1'b0;
        end else begin
            prod_vld  <= window.valid;
            prod_last <= window.last;
        end
    end

    // Stage 1 products
    always_ff @(posedge clk) begin
        for (int k = 0; k < 9; k++) begin
            prod[k] <= $signed(window.px[k]) * $signed(kernel[k]);
        end
    end

    // Sign-extend every product before summing
    always_comb begin
        tree_sum = '0;
        for (int k = 0; k < 9; k++) begin
            tree_sum = tree_sum + {{(ACC_W-PROD_W){prod[k][PROD_W-1]}}, prod[k]};
        end
    end

    // Stage 2
    always_ff @(posedge clk) begin
        if (!rst_reg_last_chan) begin
            sum.valid <= 1'b0;
            sum.last  <= 1'b0;
        end else begin
            sum.valid <= prod_vld;
            sum.last  <= prod_last;
        end
        sum.acc <= tree_sum;
    end

endmodule

//--- src/conv_output_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bias add, 32-bit saturation and the output FIFO on the master port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module conv_output_stage
    import conv_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            rst_reg_last_chan,
    input  sum_t                            sum,
    input  pix_t                            bias,
    output logic [OUT_W-1:0]                m_axis_tdata,
    output logic                            m_axis_tvalid,
    output logic                            m_axis_tlast,
    input  logic                            m_axis_tready,
    output logic [$clog2(FIFO_DEPTH+1)-1:0] free_slots,
    output logic                            retire
);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int PW    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    localparam logic signed [ACC_W-1:0] SAT_HI = {{(ACC_W-OUT_W+1){1'b0}}, {(OUT_W-1){1'b1}}};
    localparam logic signed [ACC_W-1:0] SAT_LO = {{(ACC_W-OUT_W+1){1'b1}}, {(OUT_W-1){1'b0}}};

    logic [OUT_W-1:0] data_mem [FIFO_DEPTH];
    logic             last_mem [FIFO_DEPTH];

    logic signed [ACC_W-1:0] biased;
    logic [OUT_W-1:0]        sat;
    logic [PW-1:0]           wr_ptr;
    logic [PW-1:0]           rd_ptr;
    logic [CNT_W-1:0]        count;
    logic                    pop;

    assign biased = sum.acc + {{(ACC_W-PIX_W){bias[PIX_W-1]}}, bias};

    always_comb begin
        if (biased > SAT_HI) begin
            sat = SAT_HI[OUT_W-1:0];
        end else if (biased < SAT_LO) begin
            sat = SAT_LO[OUT_W-1:0];
        end else begin
            sat = biased[OUT_W-1:0];
        end
    end

    // Credit for the window's pixel returns as it lands in the FIFO
    assign retire        = sum.valid;
    assign pop           = m_axis_tvalid && m_axis_tready;
    assign free_slots    = CNT_W'(FIFO_DEPTH) - count;
    assign m_axis_tvalid = (count != '0);
    assign m_axis_tdata  = data_mem[rd_ptr];
    assign m_axis_tlast  = m_axis_tvalid && last_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_reg_last_chan) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (sum.valid) begin
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PW'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PW'(1);
            end
            count <= count + CNT_W'(sum.valid) - CNT_W'(pop);
        end
    end

    // Write is never refused, the decoder's credit keeps a slot free
    always_ff @(posedge clk) begin
        if (sum.valid) begin
            data_mem[wr_ptr] <= sat;
            last_mem[wr_ptr] <= sum.last;
        end
    end

endmodule

//--- src/conv_datapath_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Streaming 3x3 convolution datapath, one input channel
// AXI-Stream slave of tagged beats in, saturated sums out
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module conv_datapath_top
    import conv_pkg::*;
#(
    parameter int IMG_W      = 8,
    parameter int FIFO_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst_reg_last_chan,
    input  logic [9*PIX_W-1:0] s_axis_tdata,
    input  conv_op_e           s_axis_tuser,
    input  logic               s_axis_tvalid,
    output logic               s_axis_tready,
    output logic [OUT_W-1:0]   m_axis_tdata,
    output logic               m_axis_tvalid,
    output logic               m_axis_tlast,
    input  logic               m_axis_tready
);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    pix_beat_t        pix;
    kernel_t          kernel;
    pix_t             bias;
    window_t          window;
    sum_t             sum;
    logic [CNT_W-1:0] free_slots;
    logic             retire_lb;
    logic             retire_out;

    // Decode
    conv_stream_decoder #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) decoder_i (
        .clk              (clk),
        .rst_reg_last_chan(rst_reg_last_chan),
        .s_axis_tdata     (s_axis_tdata),
        .s_axis_tuser     (s_axis_tuser),
        .s_axis_tvalid    (s_axis_tvalid),
        .s_axis_tready    (s_axis_tready),
        .free_slots       (free_slots),
        .retire_lb        (retire_lb),
        .retire_out       (retire_out),
        .pix              (pix),
        .kernel           (kernel),
        .bias             (bias)
    );

    // Execute
    conv_line_buffer #(
        .IMG_W(IMG_W)
    ) line_buffer_i (
        .clk              (clk),
        .rst_reg_last_chan(rst_reg_last_chan),
        .pix              (pix),
        .window           (window),
        .retire           (retire_lb)
    );

    conv_mac_array mac_array_i (
        .clk              (clk),
        .rst_reg_last_chan(rst_reg_last_chan),
        .window           (window),
        .kernel           (kernel),
        .sum              (sum)
    );

    // Result
    conv_output_stage #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) output_stage_i (
        .clk              (clk),
        .rst_reg_last_chan(rst_reg_last_chan),
        .sum              (sum),
        .bias             (bias),
        .m_axis_tdata     (m_axis_tdata),
        .m_axis_tvalid    (m_axis_tvalid),
        .m_axis_tlast     (m_axis_tlast),
        .m_axis_tready    (m_axis_tready),
        .free_slots       (free_slots),
        .retire           (retire_out)
    );

endmodule

//--- test/conv_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Master port monitor, compares each transfer with the expected queue
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module conv_checker
    import conv_pkg::*;
(
    input logic             clk,
    input logic             rst_reg_last_chan,
    input logic [OUT_W-1:0] m_axis_tdata,
    input logic             m_axis_tvalid,
    input logic             m_axis_tlast,
    input logic             m_axis_tready
);
    logic [OUT_W-1:0] exp_data_q [$];
    logic             exp_last_q [$];
    string            test_q [$];
    logic [OUT_W-1:0] exp_data;
    logic             exp_last;
    string            test_name;
    int               n_checked    = 0;
    int               n_errors     = 0;
    int               n_tests      = 0;
    int               test_outputs = 0;
    int               test_errors  = 0;

    task automatic push_expected(input logic [OUT_W-1:0] data, input logic last);
        exp_data_q.push_back(data);
        exp_last_q.push_back(last);
    endtask

    task automatic begin_test(input string name);
        test_q.push_back(name);
    endtask

    // Oldest expectation against each transfer
    always @(posedge clk) begin
        if (rst_reg_last_chan && m_axis_tvalid && m_axis_tready) begin
            if (exp_data_q.size() == 0) begin
                $display("ERROR at %0d ns: output %h with no result expected",
                         $time, m_axis_tdata);
                n_errors++;
            end else begin
                exp_data = exp_data_q.pop_front();
                exp_last = exp_last_q.pop_front();
                n_checked++;
                test_outputs++;
                if (m_axis_tdata !== exp_data) begin
                    $display("ERROR at %0d ns: output %0d data %h, expected %h",
                             $time, n_checked, m_axis_tdata, exp_data);
                    n_errors++;
                    test_errors++;
                end
                if (m_axis_tlast !== exp_last) begin
                    $display("ERROR at %0d ns: output %0d tlast %b, expected %b",
                             $time, n_checked, m_axis_tlast, exp_last);
                    n_errors++;
                    test_errors++;
                end
                // Frame done
                if (exp_last) begin
                    test_name = "unnamed";
                    if (test_q.size() != 0) begin
                        test_name = test_q.pop_front();
                    end
                    n_tests++;
                    $display("test %0d %s done: %0d outputs, %0d mismatches",
                             n_tests, test_name, test_outputs, test_errors);
                    test_outputs = 0;
                    test_errors  = 0;
                end
            end
        end
    end

endmodule

//--- test/conv_assertions.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream handshake and reset properties, bound to the datapath top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module conv_assertions
    import conv_pkg::*;
(
    input logic             clk,
    input logic             rst_reg_last_chan,
    input logic             s_axis_tready,
    input logic [OUT_W-1:0] m_axis_tdata,
    input logic             m_axis_tvalid,
    input logic             m_axis_tlast,
    input logic             m_axis_tready
);
    int unsigned fail_count = 0;

    master_quiet_in_reset: assert property (@(posedge clk)
        !rst_reg_last_chan |=> !m_axis_tvalid && !m_axis_tlast)
        else begin
            $error("m_axis_tvalid or m_axis_tlast high during reset");
            fail_count++;
        end

    // Held beat keeps valid, data and last
    master_stable_when_stalled: assert property (@(posedge clk)
        disable iff (!rst_reg_last_chan)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
        else begin
            $error("master beat changed while stalled");
            fail_count++;
        end

    slave_not_ready_in_reset: assert property (@(posedge clk)
        !rst_reg_last_chan |=> !s_axis_tready)
        else begin
            $error("s_axis_tready high during reset");
            fail_count++;
        end

endmodule

//--- test/conv_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the 3x3 convolution datapath
// Seeded random frames, reference model, back-pressure and watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module conv_tb
    import conv_pkg::*;
();

    localparam int IMG_W    = 8;
    localparam int N_TESTS  = 7;
    localparam int MAX_NOPS = 12;
    // One frame per test of kernel, bias, pixels and at most MAX_NOPS NOP beats
    localparam int TOTAL_BEATS = N_TESTS * (2 + IMG_W * IMG_W + MAX_NOPS);
    localparam int LIMIT_NS    = 20 * TOTAL_BEATS * 8;

    logic               clk = 1'b0;
    logic               rst_reg_last_chan;
    logic [9*PIX_W-1:0] s_axis_tdata;
    conv_op_e           s_axis_tuser;
    logic               s_axis_tvalid;
    logic               s_axis_tready;
    logic [OUT_W-1:0]   m_axis_tdata;
    logic               m_axis_tvalid;
    logic               m_axis_tlast;
    logic               m_axis_tready;

    pix_t img [IMG_W*IMG_W];
    pix_t weight [9];
    pix_t bias;
    int   ready_mode = 0;
    int   cyc        = 0;
    int   n_pushed   = 0;
    int   tb_fails   = 0;
    bit   stall_seen = 1'b0;

    always #4 clk = ~clk;

    conv_datapath_top #(.IMG_W(IMG_W), .FIFO_DEPTH(8)) dut_i (.*);

    conv_checker chk_i (.*);

    bind conv_datapath_top conv_assertions assertions_i (
        .clk              (clk),
        .rst_reg_last_chan(rst_reg_last_chan),
        .s_axis_tready    (s_axis_tready),
        .m_axis_tdata     (m_axis_tdata),
        .m_axis_tvalid    (m_axis_tvalid),
        .m_axis_tlast     (m_axis_tlast),
        .m_axis_tready    (m_axis_tready)
    );

    // Master ready is always high, low for long stretches or random
    always @(negedge clk) begin
        cyc++;
        case (ready_mode)
            0:       m_axis_tready = 1'b1;
            1:       m_axis_tready = (cyc % 36) >= 30;
            default: m_axis_tready = ($urandom % 2) != 0;
        endcase
    end

    // Mostly random with full-scale and small values mixed in
    function automatic pix_t rand_pix();
        int unsigned r;
        r = $urandom % 8;
        case (r)
            0:       return 16'sh7fff;
            1:       return 16'sh8000;
            2, 3, 4: return pix_t'($urandom % 512) - 16'sd256;
            default: return pix_t'($urandom);
        endcase
    endfunction

    function automatic logic [9*PIX_W-1:0] rand_wide();
        logic [9*PIX_W-1:0] v;
        for (int i = 0; i < 4; i++) begin
            v[i*32 +: 32] = $urandom;
        end
        v[143:128] = 16'($urandom);
        return v;
    endfunction

    // Expected result of the window ending at row r, column c
    task automatic push_window(input int r, input int c);
        longint           acc;
        logic [OUT_W-1:0] res;
        acc = longint'(bias);
        for (int k = 0; k < 9; k++) begin
            acc += longint'(img[(r - 2 + k / 3) * IMG_W + c - 2 + k % 3]) * longint'(weight[k]);
        end
        if (acc > 64'sd2147483647) begin
            res = 32'h7fff_ffff;
        end else if (acc < -64'sd2147483648) begin
            res = 32'h8000_0000;
        end else begin
            res = acc[OUT_W-1:0];
        end
        chk_i.push_expected(res, (r == IMG_W - 1) && (c == IMG_W - 1));
        n_pushed++;
    endtask

    task automatic send_beat(input conv_op_e op, input logic [9*PIX_W-1:0] data,
                             output bit stalled);
        bit taken;
        stalled       = 1'b0;
        taken         = 1'b0;
        s_axis_tuser  = op;
        s_axis_tdata  = data;
        s_axis_tvalid = 1'b1;
        while (!taken) begin
            // Ready has settled well before the rising edge
            #2;
            taken   = s_axis_tready;
            stalled |= !taken;
            @(negedge clk);
        end
        s_axis_tvalid = 1'b0;
    endtask

    task automatic idle(input int n);
        s_axis_tvalid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic drain();
        while (chk_i.n_checked != n_pushed) @(negedge clk);
    endtask

    task automatic run_test(input string name, input bit full_scale, input int rmode,
                            input bit gaps, input bit nops);
        bit                 stalled;
        int                 n_nops;
        logic [9*PIX_W-1:0] beat;
        n_nops = 0;
        // New kernel only once the previous frame has left
        drain();
        chk_i.begin_test(name);
        ready_mode = rmode;
        for (int k = 0; k < 9; k++) begin
            weight[k]              = full_scale ? 16'sh7fff : rand_pix();
            beat[k*PIX_W +: PIX_W] = weight[k];
        end
        bias = rand_pix();
        for (int i = 0; i < IMG_W * IMG_W; i++) begin
            img[i] = full_scale ? ((i / IMG_W < 4) ? 16'sh7fff : 16'sh8000) : rand_pix();
        end
        send_beat(OP_KERNEL, beat, stalled);
        if (nops) begin
            send_beat(OP_NOP, rand_wide(), stalled);
            n_nops++;
        end
        beat            = rand_wide();
        beat[PIX_W-1:0] = bias;
        send_beat(OP_BIAS, beat, stalled);
        for (int i = 0; i < IMG_W * IMG_W; i++) begin
            if (nops && n_nops < MAX_NOPS && ($urandom % 8) == 0) begin
                send_beat(OP_NOP, rand_wide(), stalled);
                n_nops++;
            end
            if (gaps) begin
                idle($urandom % 4);
            end
            beat            = rand_wide();
            beat[PIX_W-1:0] = img[i];
            send_beat(OP_PIXEL, beat, stalled);
            stall_seen |= stalled;
            if (i / IMG_W >= 2 && i % IMG_W >= 2) begin
                push_window(i / IMG_W, i % IMG_W);
            end
        end
    endtask

    // Watchdog
    initial begin
        #(LIMIT_NS);
        $display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        void'($urandom(79302));
        rst_reg_last_chan = 1'b0;
        s_axis_tvalid     = 1'b0;
        s_axis_tdata      = '0;
        s_axis_tuser      = OP_NOP;
        m_axis_tready     = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_reg_last_chan = 1'b1;
        if (m_axis_tvalid !== 1'b0) begin
            $display("ERROR at %0d ns: m_axis_tvalid high after reset", $time);
            tb_fails++;
        end
        run_test("basic", 1'b0, 0, 1'b0, 1'b0);
        run_test("saturation", 1'b1, 0, 1'b0, 1'b0);
        run_test("ready_held_low", 1'b0, 1, 1'b0, 1'b0);
        run_test("ready_random", 1'b0, 2, 1'b0, 1'b0);
        run_test("nop_beats", 1'b0, 0, 1'b0, 1'b1);
        run_test("valid_gaps", 1'b0, 0, 1'b1, 1'b0);
        run_test("all_mixed", 1'b0, 2, 1'b1, 1'b1);
        drain();
        // Room for a stray extra output to show up
        idle(20);
        if (!stall_seen) begin
            $display("Input never stalled while the output was blocked");
            tb_fails++;
        end
        if (dut_i.assertions_i.fail_count != 0) begin
            $display("Bound assertions failed %0d times", dut_i.assertions_i.fail_count);
            tb_fails++;
        end
        $display("Summary: %0d tests, %0d outputs checked, %0d mismatches, %0d other failures",
                 chk_i.n_tests, chk_i.n_checked, chk_i.n_errors, tb_fails);
        if (chk_i.n_errors == 0 && tb_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
src/conv_pkg.sv
src/conv_stream_decoder.sv
src/conv_line_buffer.sv
src/conv_mac_array.sv
src/conv_output_stage.sv
src/conv_datapath_top.sv
test/conv_checker.sv
test/conv_assertions.sv
test/conv_tb.sv

//--- Bender.yml
package:
  name: conv_datapath

sources:
  - src/conv_pkg.sv
  - src/conv_stream_decoder.sv
  - src/conv_line_buffer.sv
  - src/conv_mac_array.sv
  - src/conv_output_stage.sv
  - src/conv_datapath_top.sv
  - target: test
    files:
      - test/conv_checker.sv
      - test/conv_assertions.sv
      - test/conv_tb.sv
